//--- logic/heapPkg.sv
// Shared sizes, opcodes and bundles for the heap of fixed-size arrays.
// Every heap module imports this package.

package heapPkg;

  // ---------------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------------
  localparam int unsigned ARRAY_BITS   = 2;                 // Bits of an array number
  localparam int unsigned INDEX_BITS   = 2;                 // Bits of an element index
  localparam int unsigned ARRAY_LENGTH = 4;                 // Elements per array
  localparam int unsigned ARRAYS       = 4;                 // Arrays in the heap
  localparam int unsigned DATA_BITS    = 12;                // Element width

  typedef logic [ARRAY_BITS-1:0] arrayNumber;
  typedef logic [INDEX_BITS-1:0] elementIndex;
  typedef logic [INDEX_BITS:0]   arraySize;                 // One extra bit, holds 0 to 4
  typedef logic [DATA_BITS-1:0]  element;

  // ---------------------------------------------------------------------------
  // Encodings
  // ---------------------------------------------------------------------------
  typedef enum logic [3:0] {
    opWrite, opRead, opSize, opResize, opPush, opPop, opAlloc, opFree,
    opAdd,                                                  // Returns the new value
    opAddAfter,                                             // Returns the previous value
    opSubtract, opSubAfter, opOr, opXor, opAnd
  } heapOp;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errFreed, errOutOfBounds,
    errFull, errEmpty, errTooLarge, errOutOfMemory
  } heapError;

  typedef enum logic [2:0] {
    sizeKeep,
    sizeGrowTo,                                             // Raise to value if larger
    sizeIncrement, sizeDecrement, sizeLoad, sizeClear
  } sizeCommand;

  // ---------------------------------------------------------------------------
  // Bundles
  // ---------------------------------------------------------------------------
  typedef struct packed {
    heapOp       op;
    arrayNumber  array;
    elementIndex index;
    element      data;                                      // Value, operand or new size
  } heapRequest;

  typedef struct packed {
    element   data;
    heapError error;
  } heapResponse;

  typedef struct packed {
    heapOp       op;
    arrayNumber  array;                                     // Also addresses sizes and flags
    elementIndex index;
    element      operand;
  } storeCommand;

endpackage

//--- logic/arrayAllocator.sv
// Hands out array numbers: freed arrays come back last-in first-out,
// otherwise the high-water counter supplies a never-used array.

module arrayAllocator (
  input  logic                clock,
  input  logic                reset,
  input  heapPkg::arrayNumber array,
  input  logic                take,
  input  logic                releaseArray,
  output logic                allocated,
  output logic                neverAllocated,
  output heapPkg::arrayNumber candidate,
  output logic                candidateReady
);
  import heapPkg::*;

  logic [ARRAY_BITS:0]   highWater;                         // Arrays ever handed out
  logic [ARRAY_BITS:0]   stackTop;                          // Entries on the freed stack
  arrayNumber            freedStack [ARRAYS];
  logic [ARRAYS-1:0]     allocatedFlags;
  logic                  stackFilled;

  assign stackFilled    = stackTop != '0;
  assign candidate      = stackFilled ? freedStack[ARRAY_BITS'(stackTop - 1'b1)]
                                      : highWater[ARRAY_BITS-1:0];
  assign candidateReady = stackFilled || highWater < ARRAYS;
  assign allocated      = allocatedFlags[array];
  assign neverAllocated = {1'b0, array} >= highWater;

  // ---------------------------------------------------------------------------
  // Counters and flags
  // ---------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      highWater      <= '0;
      stackTop       <= '0;
      allocatedFlags <= '0;
    end else if (take) begin
      allocatedFlags[candidate] <= 1'b1;
      if (stackFilled) begin
        stackTop <= stackTop - 1'b1;                        // Pop freed array
      end else begin
        highWater <= highWater + 1'b1;
      end
    end else if (releaseArray) begin
      allocatedFlags[array] <= 1'b0;
      stackTop              <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseArray) freedStack[ARRAY_BITS'(stackTop)] <= array;  // Push onto stack
  end

  takeNeedsCandidate: assert property (@(posedge clock) disable iff (reset)
    take |-> candidateReady);

endmodule

//--- logic/sizeTable.sv
// Current size of every array, changed by one size command per commit.
// The size of the presented array is read combinationally.

module sizeTable (
  input  logic                clock,
  input  logic                reset,
  input  heapPkg::arrayNumber array,
  input  heapPkg::sizeCommand update,
  input  heapPkg::arraySize   value,
  output heapPkg::arraySize   size
);
  import heapPkg::*;

  arraySize sizes [ARRAYS];

  assign size = sizes[array];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARRAYS; i++) begin
        sizes[i] <= '0;                                     // All arrays empty
      end
    end else begin
      case (update)
        sizeGrowTo:    if (value > sizes[array]) sizes[array] <= value;
        sizeIncrement: sizes[array] <= sizes[array] + 1'b1;
        sizeDecrement: sizes[array] <= sizes[array] - 1'b1;
        sizeLoad:      sizes[array] <= value;
        sizeClear:     sizes[array] <= '0;
        default:       sizes[array] <= sizes[array];        // Keep
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // Bound on every array
  // ---------------------------------------------------------------------------
  for (genvar g = 0; g < ARRAYS; g++) begin : sizeBound
    sizeWithinLength: assert property (@(posedge clock) disable iff (reset)
      sizes[g] <= ARRAY_LENGTH);
  end

endmodule

//--- logic/elementStore.sv
// Element memory of all arrays with a registered read port and the
// write-back arithmetic for the read-modify-write operations.

module elementStore (
  input  logic                 clock,
  input  heapPkg::storeCommand command,
  input  logic                 writeEnable,
  output heapPkg::element      oldValue,
  output heapPkg::element      newValue
);
  import heapPkg::*;

  element memory [ARRAYS][ARRAY_LENGTH];                    // Fixed block per array

  // Old value is ready one cycle after the address
  always_ff @(posedge clock) begin
    oldValue <= memory[command.array][command.index];
    if (writeEnable) memory[command.array][command.index] <= newValue;
  end

  // ---------------------------------------------------------------------------
  // Write-back value, wraps at DATA_BITS
  // ---------------------------------------------------------------------------
  always_comb begin
    case (command.op)
      opAdd, opAddAfter:      newValue = oldValue + command.operand;
      opSubtract, opSubAfter: newValue = oldValue - command.operand;
      opOr:                   newValue = oldValue | command.operand;
      opXor:                  newValue = oldValue ^ command.operand;
      opAnd:                  newValue = oldValue & command.operand;
      default:                newValue = command.operand;  // Write and push store as is
    endcase
  end

endmodule

//--- logic/heapSequencer.sv
// Two-cycle operation control for the heap: fetch reads storage and
// settles the error, commit applies updates and registers the response.

module heapSequencer (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  heapPkg::heapRequest  request,
  input  heapPkg::arraySize    size,
  input  logic                 allocated,
  input  logic                 neverAllocated,
  input  heapPkg::arrayNumber  candidate,
  input  logic                 candidateReady,
  input  heapPkg::element      oldValue,
  input  heapPkg::element      newValue,
  output heapPkg::storeCommand command,
  output logic                 writeEnable,
  output heapPkg::sizeCommand  sizeUpdate,
  output heapPkg::arraySize    sizeValue,
  output logic                 take,
  output logic                 releaseArray,
  output heapPkg::heapResponse response,
  output logic                 busy,
  output logic                 done
);
  import heapPkg::*;

  typedef enum logic [1:0] {stateIdle, stateFetch, stateCommit} sequencerState;

  sequencerState state;
  heapRequest    pending;                                   // Request held for the operation
  heapError      check;                                     // Error seen on current storage
  heapError      fault;                                     // Error settled in fetch
  element        result;                                    // Response data before the zero mask
  logic          commitOk;

  assign busy     = state != stateIdle;
  assign commitOk = state == stateCommit && fault == errNone;

  // ---------------------------------------------------------------------------
  // Storage addressing
  // ---------------------------------------------------------------------------
  always_comb begin
    command.op      = pending.op;
    command.array   = (pending.op == opAlloc) ? candidate : pending.array;  // Alloc clears its size
    command.operand = pending.data;
    case (pending.op)
      opPush:  command.index = size[INDEX_BITS-1:0];        // Next free slot
      opPop:   command.index = elementIndex'(size - 1'b1);  // Last element
      default: command.index = pending.index;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Error priority
  // ---------------------------------------------------------------------------
  always_comb begin
    check = errNone;
    if (pending.op == opAlloc) begin
      if (!candidateReady) check = errOutOfMemory;
    end else if (neverAllocated) begin
      check = errNotAllocated;                              // Beats freed
    end else if (!allocated) begin
      check = errFreed;
    end else begin
      case (pending.op)
        opRead, opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd:
          if (arraySize'(pending.index) >= size) check = errOutOfBounds;
        opPush:   if (size == ARRAY_LENGTH) check = errFull;
        opPop:    if (size == 0) check = errEmpty;
        opResize: if (pending.data > ARRAY_LENGTH) check = errTooLarge;
        default:  check = errNone;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // Commit strobes and response data
  // ---------------------------------------------------------------------------
  always_comb begin
    writeEnable  = 1'b0;
    sizeUpdate   = sizeKeep;
    take         = 1'b0;
    releaseArray = 1'b0;
    sizeValue    = (pending.op == opResize) ? pending.data[INDEX_BITS:0]
                                            : arraySize'(pending.index) + 1'b1;
    if (commitOk) begin
      case (pending.op)
        opWrite: begin
          writeEnable = 1'b1;
          sizeUpdate  = sizeGrowTo;                         // Size becomes index plus one
        end
        opPush: begin
          writeEnable = 1'b1;
          sizeUpdate  = sizeIncrement;
        end
        opPop:    sizeUpdate = sizeDecrement;
        opResize: sizeUpdate = sizeLoad;
        opAlloc: begin
          take       = 1'b1;
          sizeUpdate = sizeClear;                           // Reused array starts empty
        end
        opFree: releaseArray = 1'b1;
        opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd:
          writeEnable = 1'b1;
        default: writeEnable = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (pending.op)
      opWrite, opPush:                       result = pending.data;
      opRead, opPop, opAddAfter, opSubAfter: result = oldValue;
      opSize:                                result = element'(size);
      opResize:                              result = pending.data;   // New size
      opAlloc:                               result = element'(candidate);
      opFree:                                result = element'(pending.array);
      default:                               result = newValue;
    endcase
  end

  // ---------------------------------------------------------------------------
  // State machine
  // ---------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= stateIdle;
      done     <= 1'b0;
      response <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        stateIdle:  if (start) state <= stateFetch;
        stateFetch: state <= stateCommit;                   // Storage reads land here
        stateCommit: begin
          state          <= stateIdle;
          done           <= 1'b1;
          response.data  <= (fault == errNone) ? result : '0;
          response.error <= fault;
        end
        default: state <= stateIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stateIdle && start) pending <= request;
    if (state == stateFetch) fault <= check;
  end

  startOnlyWhenIdle: assert property (@(posedge clock) disable iff (reset) start |-> !busy);
  doneSingleCycle:   assert property (@(posedge clock) disable iff (reset) done |=> !done);

endmodule

//--- logic/heapMemory.sv
// Heap of fixed-size arrays driven one request at a time.
// Pulse start with a request while busy is low; done marks the response.

module heapMemory (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  heapPkg::heapRequest  request,
  output heapPkg::heapResponse response,
  output logic                 busy,
  output logic                 done
);
  import heapPkg::*;

  storeCommand command;                                     // Addresses all three stores
  logic        writeEnable;
  sizeCommand  sizeUpdate;
  arraySize    sizeValue;
  arraySize    size;
  logic        take;
  logic        releaseArray;
  logic        allocated;
  logic        neverAllocated;
  arrayNumber  candidate;
  logic        candidateReady;
  element      oldValue;
  element      newValue;

  heapSequencer sequencer (
    .clock, .reset, .start, .request,
    .size, .allocated, .neverAllocated, .candidate, .candidateReady,
    .oldValue, .newValue,
    .command, .writeEnable, .sizeUpdate, .sizeValue, .take, .releaseArray,
    .response, .busy, .done
  );

  arrayAllocator allocator (
    .clock, .reset,
    .array (command.array),
    .take, .releaseArray,
    .allocated, .neverAllocated, .candidate, .candidateReady
  );

  sizeTable sizes (
    .clock, .reset,
    .array  (command.array),
    .update (sizeUpdate),
    .value  (sizeValue),
    .size
  );

  elementStore store (
    .clock, .command, .writeEnable, .oldValue, .newValue
  );

endmodule

//--- sim/heapMemoryTb.sv
// Self-checking testbench for the heap of fixed-size arrays.
// Requests go through a reference model; concurrent assertions compare
// every response and the start/busy/done timing with that model.

module heapMemoryTb;
  timeunit 1ns;
  timeprecision 1ps;
  import heapPkg::*;

  localparam int TimeoutCycles = 8;                         // Per wait for done

  logic        clock;
  logic        reset;
  logic        start;
  heapRequest  request;
  heapResponse response;
  logic        busy;
  logic        done;

  heapResponse expected;                                    // Model result of current request
  string       testName;
  logic [31:0] randomState;

  // Reference model state
  element     modelData [ARRAYS][ARRAY_LENGTH];
  arraySize   modelSize [ARRAYS];
  logic       modelAllocated [ARRAYS];
  arrayNumber freedStack [$];                               // Back is the top
  int         highWater;

  heapOp arithOps [7] = '{opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd};

  heapMemory UUT (
    .clock, .reset, .start, .request, .response, .busy, .done
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;                             // 100 ns period
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  idleAfterReset: assert property (@(posedge clock)
    reset |=> !busy && !done && response == '0)
    else begin
      $display("DUT not idle with cleared response after reset");
      $display("RESULT: FAIL");
      $fatal(1);
    end

  donePulseTiming: assert property (@(posedge clock) disable iff (reset)
    start |=> !done ##1 !done ##1 done ##1 !done)
    else begin
      $display("done did not pulse for one cycle two cycles after start in %s", testName);
      $display("RESULT: FAIL");
      $fatal(1);
    end

  busyDuringOperation: assert property (@(posedge clock) disable iff (reset)
    start |=> busy ##1 busy ##1 !busy)
    else begin
      $display("busy did not cover the two operation cycles in %s", testName);
      $display("RESULT: FAIL");
      $fatal(1);
    end

  responseMatchesModel: assert property (@(posedge clock) disable iff (reset)
    done |-> response == expected)
    else begin
      $display("MISMATCH %s expected data %0h error %0d actual data %0h error %0d",
               testName, expected.data, expected.error, response.data, response.error);
      $display("RESULT: FAIL");
      $fatal(1);
    end

  // ------------------------------------------------------------------------
  // Model and helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] nextRandom();
    randomState ^= randomState << 13;                       // xorshift32
    randomState ^= randomState >> 17;
    randomState ^= randomState << 5;
    return randomState;
  endfunction

  function automatic element combine(input heapOp op, input element a, input element b);
    case (op)
      opAdd, opAddAfter:      return a + b;                 // Wraps at 12 bits
      opSubtract, opSubAfter: return a - b;
      opOr:                   return a | b;
      opXor:                  return a ^ b;
      default:                return a & b;
    endcase
  endfunction

  function automatic heapResponse modelStep(input heapRequest r);
    heapResponse e;
    arraySize    grown;
    element      previous;
    e.data  = '0;
    e.error = errNone;
    if (r.op == opAlloc) begin
      if (freedStack.size() != 0) e.data = element'(freedStack.pop_back());  // LIFO reuse
      else if (highWater < ARRAYS) begin
        e.data = element'(highWater);
        highWater++;
      end else e.error = errOutOfMemory;
      if (e.error == errNone) begin
        modelAllocated[e.data[ARRAY_BITS-1:0]] = 1'b1;
        modelSize[e.data[ARRAY_BITS-1:0]]      = '0;
      end
      return e;
    end
    if (int'(r.array) >= highWater) e.error = errNotAllocated;  // Beats freed
    else if (!modelAllocated[r.array]) e.error = errFreed;
    if (e.error != errNone) return e;
    grown = arraySize'(r.index) + arraySize'(1);
    case (r.op)
      opWrite: begin
        modelData[r.array][r.index] = r.data;
        if (grown > modelSize[r.array]) modelSize[r.array] = grown;
        e.data = r.data;
      end
      opRead:
        if (arraySize'(r.index) >= modelSize[r.array]) e.error = errOutOfBounds;
        else e.data = modelData[r.array][r.index];
      opSize: e.data = element'(modelSize[r.array]);
      opResize:
        if (r.data > ARRAY_LENGTH) e.error = errTooLarge;
        else begin
          modelSize[r.array] = arraySize'(r.data);
          e.data = r.data;
        end
      opPush:
        if (modelSize[r.array] == ARRAY_LENGTH) e.error = errFull;
        else begin
          modelData[r.array][modelSize[r.array][INDEX_BITS-1:0]] = r.data;
          modelSize[r.array] = modelSize[r.array] + arraySize'(1);
          e.data = r.data;
        end
      opPop:
        if (modelSize[r.array] == 0) e.error = errEmpty;
        else begin
          modelSize[r.array] = modelSize[r.array] - arraySize'(1);
          e.data = modelData[r.array][modelSize[r.array][INDEX_BITS-1:0]];
        end
      opFree: begin
        modelAllocated[r.array] = 1'b0;
        freedStack.push_back(r.array);
        e.data = element'(r.array);
      end
      default:                                              // Read-modify-write ops
        if (arraySize'(r.index) >= modelSize[r.array]) e.error = errOutOfBounds;
        else begin
          previous = modelData[r.array][r.index];
          modelData[r.array][r.index] = combine(r.op, previous, r.data);
          if (r.op == opAddAfter || r.op == opSubAfter) e.data = previous;
          else e.data = modelData[r.array][r.index];
        end
    endcase
    return e;
  endfunction

  // Issues one request and waits for done
  task automatic issue(input heapOp op, input arrayNumber array,
                       input elementIndex index, input element data);
    heapRequest r;
    int         waited;
    r.op    = op;
    r.array = array;
    r.index = index;
    r.data  = data;
    @(negedge clock);
    expected = modelStep(r);
    request  = r;
    start    = 1'b1;
    @(negedge clock);
    start  = 1'b0;
    waited = 0;
    while (!done) begin
      if (waited == TimeoutCycles) begin
        $display("Timeout waiting for done in %s", testName);
        $display("RESULT: FAIL");
        $fatal(1);
      end
      @(negedge clock);
      waited++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin
    reset       = 1'b1;
    start       = 1'b0;
    request     = '0;
    expected    = '0;
    testName    = "reset";
    randomState = 32'd78;
    highWater   = 0;
    for (int a = 0; a < ARRAYS; a++) begin
      modelSize[a]      = '0;
      modelAllocated[a] = 1'b0;
    end
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    testName = "neverAllocated";
    issue(opRead, 2'd2, 2'd0, '0);
    issue(opWrite, 2'd0, 2'd1, 12'h123);

    testName = "allocate";
    for (int i = 0; i < 5; i++) issue(opAlloc, 2'd0, 2'd0, '0);  // Fifth runs out

    testName = "writeRead";
    issue(opWrite, 2'd0, 2'd2, element'(nextRandom()));
    issue(opSize, 2'd0, 2'd0, '0);                          // Grown to three
    issue(opRead, 2'd0, 2'd2, '0);
    issue(opRead, 2'd0, 2'd3, '0);
    issue(opWrite, 2'd0, 2'd0, element'(nextRandom()));
    issue(opWrite, 2'd0, 2'd1, element'(nextRandom()));
    issue(opRead, 2'd0, 2'd0, '0);
    issue(opSize, 2'd0, 2'd0, '0);                          // Lower writes keep three
    issue(opResize, 2'd0, 2'd0, 12'd5);
    issue(opResize, 2'd0, 2'd0, 12'd2);
    issue(opRead, 2'd0, 2'd2, '0);                          // Now out of bounds
    issue(opRead, 2'd0, 2'd1, '0);

    testName = "pushPop";
    issue(opPop, 2'd1, 2'd0, '0);
    for (int i = 0; i < 5; i++) issue(opPush, 2'd1, 2'd0, element'(nextRandom()));
    issue(opSize, 2'd1, 2'd0, '0);
    for (int i = 0; i < 5; i++) issue(opPop, 2'd1, 2'd0, '0);  // Last one empty
    issue(opSize, 2'd1, 2'd0, '0);

    testName = "freeReuse";
    issue(opWrite, 2'd1, 2'd3, 12'h5a5);                    // Size four before free
    issue(opPush, 2'd2, 2'd0, 12'h055);                     // Size one before free
    issue(opFree, 2'd1, 2'd0, '0);
    issue(opFree, 2'd2, 2'd0, '0);
    issue(opRead, 2'd1, 2'd0, '0);
    issue(opPush, 2'd2, 2'd0, 12'h0aa);
    issue(opFree, 2'd2, 2'd0, '0);
    issue(opAlloc, 2'd0, 2'd0, '0);                         // Gets 2 back
    issue(opSize, 2'd2, 2'd0, '0);
    issue(opAlloc, 2'd0, 2'd0, '0);                         // Then 1
    issue(opSize, 2'd1, 2'd0, '0);
    issue(opAdd, 2'd2, 2'd0, 12'h001);

    testName = "arithmetic";
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      issue(opWrite, 2'd3, elementIndex'(i), element'(nextRandom()));
    end
    for (int i = 0; i < 28; i++) begin
      automatic elementIndex index = elementIndex'(nextRandom());
      issue(arithOps[nextRandom() % 7], 2'd3, index, element'(nextRandom()));
      issue(opRead, 2'd3, index, '0);                       // Confirm stored value
    end
    for (int i = 0; i < ARRAY_LENGTH; i++) issue(opRead, 2'd3, elementIndex'(i), '0);

    repeat (3) @(negedge clock);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- files.f
logic/heapPkg.sv
logic/arrayAllocator.sv
logic/sizeTable.sv
logic/elementStore.sv
logic/heapSequencer.sv
logic/heapMemory.sv
sim/heapMemoryTb.sv

//--- Bender.yml
package:
  name: heap_memory

dependencies: {}

sources:
  - logic/heapPkg.sv
  - logic/arrayAllocator.sv
  - logic/sizeTable.sv
  - logic/elementStore.sv
  - logic/heapSequencer.sv
  - logic/heapMemory.sv
  - target: simulation
    files:
      - sim/heapMemoryTb.sv
